// File: design/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // projection line geometry
    localparam int line_size = 128;
    localparam int s_width = 7;

    // sample and pixel widths
    localparam int sample_width = 12;
    localparam int pixel_width = sample_width + 1;

    // mapper accumulator, signed fixed point
    localparam int accu_width = 18;
    localparam int accu_frac = 8;
    localparam int accu_int_width = accu_width - accu_frac;

    // row pass counter, wide enough to hold line_size
    localparam int pixel_count_width = 8;

    // cycles from shift_en to pixel_valid
    localparam int pipe_latency = 2;
    localparam int drain_width = 2;

    // projection line address
    typedef logic [s_width-1:0] s_val_t;

    // one projection sample, unsigned
    typedef logic [sample_width-1:0] sample_t;

    // sum of two angle contributions
    typedef logic [pixel_width-1:0] pixel_t;

    // two's complement, accu_frac fractional bits
    typedef logic signed [accu_width-1:0] accu_t;

    typedef logic [pixel_count_width-1:0] pixel_count_t;

    typedef logic [drain_width-1:0] drain_count_t;

    typedef enum logic
    {
        ready_s,
        mapping_s
    } mapper_state_t;

endpackage

`default_nettype wire

// File: design/nabp_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_shifter
(
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    output logic kick,
    output logic shift_en,
    output logic done,
    output logic busy
);
    import nabp_pkg::*;

    pixel_count_t shift_count;
    logic running;
    drain_count_t drain_count;
    logic start_accepted;

    // a start during a pass is dropped
    assign start_accepted = start && !busy;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            kick <= 1'b0;
        end
        else
        begin
            kick <= start_accepted;
        end
    end

    // shift phase, one cycle per pixel of the row
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            running <= 1'b0;
            shift_count <= '0;
        end
        else if (kick)
        begin
            running <= 1'b1;
            shift_count <= '0;
        end
        else if (running)
        begin
            shift_count <= shift_count + 1'b1;
            if (done)
            begin
                running <= 1'b0;
            end
        end
    end

    assign shift_en = running;
    assign done = running && (shift_count == pixel_count_t'(line_size - 1));

    // keep busy while the last pixels pass through the read and sum stages
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            drain_count <= '0;
        end
        else if (done)
        begin
            drain_count <= drain_count_t'(pipe_latency);
        end
        else if (drain_count != '0)
        begin
            drain_count <= drain_count - 1'b1;
        end
    end

    assign busy = kick || running || (drain_count != '0);

endmodule

`default_nettype wire

// File: design/nabp_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_mapper
(
    input  logic             clk,
    input  logic             reset_n,
    input  nabp_pkg::accu_t  accu_init,
    input  nabp_pkg::accu_t  accu_base,
    input  logic             kick,
    input  logic             shift_en,
    input  logic             done,
    output nabp_pkg::s_val_t s_val,
    output logic             in_range,
    output logic             rm_en
);
    import nabp_pkg::*;

    mapper_state_t state;
    mapper_state_t next_state;
    accu_t accu;
    logic [accu_int_width-1:0] accu_floor;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
            begin
                if (kick)
                begin
                    next_state = mapping_s;
                end
            end
            mapping_s:
            begin
                if (done)
                begin
                    next_state = ready_s;
                end
            end
            default:
            begin
                next_state = ready_s;
            end
        endcase
    end

    // preload while idle so pixel 0 sees the initial value
    always_ff @(posedge clk)
    begin
        if (state == ready_s)
        begin
            accu <= accu_init;
        end
        else if (shift_en)
        begin
            accu <= accu + accu_base;
        end
    end

    // dropping the fraction bits floors toward minus infinity
    assign accu_floor = accu[accu_width-1:accu_frac];
    assign s_val = accu_floor[s_width-1:0];

    // non-negative and no bits set above the line address
    assign in_range = (state == mapping_s)
                   && !accu_floor[accu_int_width-1]
                   && (accu_floor[accu_int_width-2:s_width] == '0);

    assign rm_en = shift_en;

endmodule

`default_nettype wire

// File: design/nabp_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_line_buffer
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              wr_en,
    input  nabp_pkg::s_val_t  wr_addr,
    input  nabp_pkg::sample_t wr_data,
    input  logic              rd_en,
    input  logic              rd_in_range,
    input  nabp_pkg::s_val_t  rd_addr,
    output nabp_pkg::sample_t rd_data,
    output logic              rd_valid
);
    import nabp_pkg::*;

    sample_t mem [line_size];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

    // out of range reads still fetch, but are flagged invalid
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en && rd_in_range;
        end
    end

endmodule

`default_nettype wire

// File: design/nabp_pixel_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_pixel_accumulator
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              pixel_en,
    input  nabp_pkg::sample_t data_a,
    input  nabp_pkg::sample_t data_b,
    input  logic              valid_a,
    input  logic              valid_b,
    output nabp_pkg::pixel_t  pixel_value,
    output logic              pixel_valid
);
    import nabp_pkg::*;

    logic pixel_en_d;
    sample_t contrib_a;
    sample_t contrib_b;

    // line up with the registered line buffer read
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pixel_en_d <= 1'b0;
        end
        else
        begin
            pixel_en_d <= pixel_en;
        end
    end

    // an address off the line adds nothing
    assign contrib_a = valid_a ? data_a : '0;
    assign contrib_b = valid_b ? data_b : '0;

    always_ff @(posedge clk)
    begin
        if (pixel_en_d)
        begin
            pixel_value <= pixel_t'(contrib_a) + pixel_t'(contrib_b);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pixel_valid <= 1'b0;
        end
        else
        begin
            pixel_valid <= pixel_en_d;
        end
    end

endmodule

`default_nettype wire

// File: design/nabp_top.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_top
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  logic              line_wr_en,
    input  logic              line_wr_sel,
    input  nabp_pkg::s_val_t  line_wr_addr,
    input  nabp_pkg::sample_t line_wr_data,
    input  nabp_pkg::accu_t   accu_init_a,
    input  nabp_pkg::accu_t   accu_base_a,
    input  nabp_pkg::accu_t   accu_init_b,
    input  nabp_pkg::accu_t   accu_base_b,
    output logic              busy,
    output logic              pixel_valid,
    output nabp_pkg::pixel_t  pixel_value
);
    import nabp_pkg::*;

    // shifter to mappers
    logic kick;
    logic shift_en;
    logic done;

    // mapper a to line buffer a
    s_val_t s_val_a;
    logic in_range_a;
    logic rm_en_a;

    // mapper b to line buffer b
    s_val_t s_val_b;
    logic in_range_b;
    logic rm_en_b;

    // line buffers to accumulator
    sample_t rd_data_a;
    sample_t rd_data_b;
    logic rd_valid_a;
    logic rd_valid_b;

    nabp_shifter i_shifter
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .kick     (kick),
        .shift_en (shift_en),
        .done     (done),
        .busy     (busy)
    );

    nabp_mapper i_mapper_a
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .accu_init (accu_init_a),
        .accu_base (accu_base_a),
        .kick      (kick),
        .shift_en  (shift_en),
        .done      (done),
        .s_val     (s_val_a),
        .in_range  (in_range_a),
        .rm_en     (rm_en_a)
    );

    nabp_mapper i_mapper_b
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .accu_init (accu_init_b),
        .accu_base (accu_base_b),
        .kick      (kick),
        .shift_en  (shift_en),
        .done      (done),
        .s_val     (s_val_b),
        .in_range  (in_range_b),
        .rm_en     (rm_en_b)
    );

    // line_wr_sel low writes angle a, high writes angle b
    nabp_line_buffer i_line_buffer_a
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (line_wr_en && !line_wr_sel),
        .wr_addr     (line_wr_addr),
        .wr_data     (line_wr_data),
        .rd_en       (rm_en_a),
        .rd_in_range (in_range_a),
        .rd_addr     (s_val_a),
        .rd_data     (rd_data_a),
        .rd_valid    (rd_valid_a)
    );

    nabp_line_buffer i_line_buffer_b
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (line_wr_en && line_wr_sel),
        .wr_addr     (line_wr_addr),
        .wr_data     (line_wr_data),
        .rd_en       (rm_en_b),
        .rd_in_range (in_range_b),
        .rd_addr     (s_val_b),
        .rd_data     (rd_data_b),
        .rd_valid    (rd_valid_b)
    );

    // pixel timing follows the shifter, not the per angle valids
    nabp_pixel_accumulator i_pixel_accumulator
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .pixel_en    (shift_en),
        .data_a      (rd_data_a),
        .data_b      (rd_data_b),
        .valid_a     (rd_valid_a),
        .valid_b     (rd_valid_b),
        .pixel_value (pixel_value),
        .pixel_valid (pixel_valid)
    );

endmodule

`default_nettype wire

// File: verification/nabp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_tb;
    import nabp_pkg::*;

    localparam int num_tests = 8;
    localparam int valid_timeout = 50;
    localparam int busy_timeout = 50;
    localparam int idle_window = 20;

    logic clk = 1'b0;
    logic reset_n;
    logic start;
    logic line_wr_en;
    logic line_wr_sel;
    s_val_t line_wr_addr;
    sample_t line_wr_data;
    accu_t accu_init_a;
    accu_t accu_base_a;
    accu_t accu_init_b;
    accu_t accu_base_b;
    logic busy;
    logic pixel_valid;
    pixel_t pixel_value;

    // model copies of both projection lines
    sample_t line_a [line_size];
    sample_t line_b [line_size];

    // test table
    string test_name [num_tests];
    int init_a_tab [num_tests];
    int base_a_tab [num_tests];
    int init_b_tab [num_tests];
    int base_b_tab [num_tests];
    bit reload_tab [num_tests];
    bit restart_tab [num_tests];

    int pass_count;
    int fail_count;
    int errors;

    nabp_top i_nabp_top
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .line_wr_en   (line_wr_en),
        .line_wr_sel  (line_wr_sel),
        .line_wr_addr (line_wr_addr),
        .line_wr_data (line_wr_data),
        .accu_init_a  (accu_init_a),
        .accu_base_a  (accu_base_a),
        .accu_init_b  (accu_init_b),
        .accu_base_b  (accu_base_b),
        .busy         (busy),
        .pixel_valid  (pixel_valid),
        .pixel_value  (pixel_value)
    );

    always #5 clk = ~clk;

    task automatic add_test(input int k, input string name, input int ia, input int ba,
                            input int ib, input int bb, input bit reload, input bit restart);
        test_name[k] = name;
        init_a_tab[k] = ia;
        base_a_tab[k] = ba;
        init_b_tab[k] = ib;
        base_b_tab[k] = bb;
        reload_tab[k] = reload;
        restart_tab[k] = restart;
    endtask

    // positions are in units of 1/256 of a sample
    task automatic fill_table();
        add_test(0, "identity", 0, 256, 0, 256, 1'b0, 1'b0);
        add_test(1, "fractional_step", 832, 90, 128, 200, 1'b0, 1'b0);
        add_test(2, "negative_base", 32712, -384, 30784, -300, 1'b0, 1'b0);
        add_test(3, "above_on_a", 16384, 256, 0, 256, 1'b0, 1'b0);
        add_test(4, "below_on_b", 0, 128, -10240, 256, 1'b0, 1'b0);
        add_test(5, "both_outside", 128000, 0, -768, -1, 1'b0, 1'b0);
        add_test(6, "restart_while_busy", 2560, 100, 0, 256, 1'b0, 1'b1);
        add_test(7, "identity_reload", 0, 256, 0, 256, 1'b1, 1'b0);
    endtask

    task automatic write_line(input bit sel);
        sample_t data;
        for (int a = 0; a < line_size; a++)
        begin
            @(negedge clk);
            data = sample_t'($urandom);
            line_wr_en = 1'b1;
            line_wr_sel = sel;
            line_wr_addr = s_val_t'(a);
            line_wr_data = data;
            if (sel)
            begin
                line_b[s_val_t'(a)] = data;
            end
            else
            begin
                line_a[s_val_t'(a)] = data;
            end
        end
        @(negedge clk);
        line_wr_en = 1'b0;
    endtask

    // sample picked by one angle for pixel idx, zero off the line
    function automatic int contribution(input int init, input int base, input int idx,
                                        input bit sel);
        int pos;
        int addr;
        pos = init + idx * base;
        // floor of pos / 256
        if (pos >= 0)
        begin
            addr = pos / 256;
        end
        else
        begin
            addr = -((-pos + 255) / 256);
        end
        if (addr < 0 || addr >= line_size)
        begin
            return 0;
        end
        return sel ? int'(line_b[s_val_t'(addr)]) : int'(line_a[s_val_t'(addr)]);
    endfunction

    task automatic run_test(input int k);
        int idx;
        int cycles;
        pixel_t expected;
        errors = 0;
        accu_init_a = accu_t'(init_a_tab[k]);
        accu_base_a = accu_t'(base_a_tab[k]);
        accu_init_b = accu_t'(init_b_tab[k]);
        accu_base_b = accu_t'(base_b_tab[k]);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (!busy)
        begin
            $display("test %s: busy is not high the cycle after start", test_name[k]);
            errors++;
        end
        // optional second strobe, must be ignored
        @(negedge clk);
        start = restart_tab[k];
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!pixel_valid && cycles < valid_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!pixel_valid)
        begin
            $display("test %s: pixel_valid never went high after start", test_name[k]);
            errors++;
        end
        else
        begin
            idx = 0;
            while (idx < line_size && pixel_valid)
            begin
                expected = pixel_t'(contribution(init_a_tab[k], base_a_tab[k], idx, 1'b0)
                                  + contribution(init_b_tab[k], base_b_tab[k], idx, 1'b1));
                if (pixel_value !== expected)
                begin
                    $display("Mismatch test %s pixel %0d: expected %0d, actual %0d",
                             test_name[k], idx, expected, pixel_value);
                    errors++;
                end
                if (!busy)
                begin
                    $display("test %s: busy dropped during pixel %0d", test_name[k], idx);
                    errors++;
                end
                idx++;
                @(negedge clk);
            end
            if (idx != line_size)
            begin
                $display("test %s: burst ended after %0d pixels instead of %0d",
                         test_name[k], idx, line_size);
                errors++;
            end
            else if (pixel_valid)
            begin
                $display("test %s: pixel_valid still high after the last pixel", test_name[k]);
                errors++;
            end
        end
        cycles = 0;
        while (busy && cycles < busy_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (busy)
        begin
            $display("test %s: busy never went low after the pass", test_name[k]);
            errors++;
        end
        // no second burst may follow
        for (int c = 0; c < idle_window; c++)
        begin
            if (pixel_valid || busy)
            begin
                $display("test %s: unexpected activity after the pass", test_name[k]);
                errors++;
            end
            @(negedge clk);
        end
        if (errors == 0)
        begin
            pass_count++;
            $display("test %s: ok", test_name[k]);
        end
        else
        begin
            fail_count++;
            $display("test %s: %0d errors", test_name[k], errors);
        end
    endtask

    initial
    begin
        void'($urandom(32'h1dce));
        reset_n = 1'b0;
        start = 1'b0;
        line_wr_en = 1'b0;
        line_wr_sel = 1'b0;
        line_wr_addr = '0;
        line_wr_data = '0;
        accu_init_a = '0;
        accu_base_a = '0;
        accu_init_b = '0;
        accu_base_b = '0;
        pass_count = 0;
        fail_count = 0;
        fill_table();
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        write_line(1'b0);
        write_line(1'b1);
        for (int k = 0; k < num_tests; k++)
        begin
            // fresh data on line a before this pass
            if (reload_tab[k])
            begin
                write_line(1'b0);
            end
            run_test(k);
        end
        $display("pass count %0d, fail count %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/nabp_pkg.sv
design/nabp_shifter.sv
design/nabp_mapper.sv
design/nabp_line_buffer.sv
design/nabp_pixel_accumulator.sv
design/nabp_top.sv
verification/nabp_tb.sv

// File: run.sh
#!/bin/sh
# build and run the nabp testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module nabp_tb \
    -f filelist.f \
    -o nabp_sim

./obj_dir/nabp_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
